//--- logic/global_pkg.sv
// ==========================================================================
// datapath types shared by the matrix-vector engine
// ==========================================================================
package global_pkg;

	// largest supported matrix dimension
	localparam int MAX_N = 8;

	// one matrix or vector element
	// unsigned 8 bit
	typedef logic [7:0] data_t;

	// row sum
	// eight 16 bit products need 19 bits
	typedef logic [18:0] acc_t;

	// matrix dimension as set by the host
	// legal values 1 to MAX_N
	typedef logic [3:0] nibble_t;

	// row or column index inside the matrix
	typedef logic [2:0] idx_t;

endpackage

//--- logic/fifo_pkg.sv
// ==========================================================================
// sizing of the matrix FIFO
// ==========================================================================
package fifo_pkg;

	// address bits of the matrix storage
	// 8 x 8 elements fit in 2**6 words
	localparam int COUNT_N_N = 6;

	// number of words in the storage array
	localparam int FIFO_DEPTH = 64;

	// read or write address into the storage array
	typedef logic [COUNT_N_N-1:0] M_address_t;

endpackage

//--- logic/fsm_fifo.sv
`timescale 1ns/1ps

module fsm_fifo (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  logic pop,
	input  logic full,
	input  logic empty,
	output logic wr_en,
	output logic rd_en
);

	// ======================================================================
	// request gating
	// ======================================================================

	// write only with room left
	assign wr_en = push & ~full;

	// read only with data held
	assign rd_en = pop & ~empty;

	// ======================================================================
	// checks
	// ======================================================================

	// a write leaves at least one element behind
	a_wr_fills: assert property (@(posedge clk) disable iff (reset)
		wr_en |=> !empty)
		else $error("FIFO empty right after a write");

	// a read leaves room for the next write
	a_rd_frees: assert property (@(posedge clk) disable iff (reset)
		rd_en |=> !full)
		else $error("FIFO full right after a read");

endmodule

//--- logic/ram_matrix.sv
`timescale 1ns/1ps

module ram_matrix import global_pkg::*, fifo_pkg::*; (
	input  logic       clk,
	input  logic       wr_en,
	input  logic       rd_en,
	input  M_address_t count_push,
	input  M_address_t count_pop,
	input  data_t      data_in,
	output data_t      data_out
);

	// element storage
	data_t mem [FIFO_DEPTH];

	// write port
	// lands on the edge of wr_en
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[count_push] <= data_in;
		end
	end

	// read port, one cycle latency
	// output holds between reads
	always_ff @(posedge clk) begin
		if (rd_en) begin
			data_out <= mem[count_pop];
		end
	end

endmodule

//--- logic/pointers_m.sv
`timescale 1ns/1ps

module pointers_m import global_pkg::*, fifo_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       push,
	input  logic       pop,
	input  nibble_t    n,
	output M_address_t count_push,
	output M_address_t count_pop,
	output logic       full,
	output logic       empty,
	output logic       ready
);

	// fill count needs one bit more than the address
	logic [COUNT_N_N:0] fill;

	// elements in one full matrix
	logic [COUNT_N_N:0] n_sq;

	// ======================================================================
	// pointers and fill count
	// ======================================================================

	// both pointers wrap through the whole array
	always_ff @(posedge clk) begin
		if (reset) begin
			count_push <= '0;
			count_pop  <= '0;
		end else begin
			if (push) begin
				count_push <= count_push + M_address_t'(1);
			end
			if (pop) begin
				count_pop <= count_pop + M_address_t'(1);
			end
		end
	end

	// push and pop together leave the count alone
	always_ff @(posedge clk) begin
		if (reset) begin
			fill <= '0;
		end else begin
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// status straight from the count
	assign full  = (fill == (COUNT_N_N+1)'(FIFO_DEPTH));
	assign empty = (fill == '0);

	// ======================================================================
	// matrix ready
	// ======================================================================

	// max 8 x 8 = 64, fits the count width
	assign n_sq = (COUNT_N_N+1)'(n) * (COUNT_N_N+1)'(n);

	// goes high the cycle after a whole matrix is held
	always_ff @(posedge clk) begin
		if (reset) begin
			ready <= 1'b0;
		end else begin
			ready <= (fill >= n_sq);
		end
	end

endmodule

//--- logic/fifo_matrix.sv
`timescale 1ns/1ps

module fifo_matrix import global_pkg::*, fifo_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    push,
	input  logic    pop,
	input  data_t   data_in,
	input  nibble_t n,
	output logic    full,
	output logic    empty,
	output data_t   data_out,
	output logic    ready
);

	// gated enables shared by memory and pointers
	logic wr_en_w;
	logic rd_en_w;

	// current write and read addresses
	M_address_t count_push_w;
	M_address_t count_pop_w;

	// request gating against full and empty
	fsm_fifo fsm_fifo_inst (
		.clk   (clk),
		.reset (reset),
		.push  (push),
		.pop   (pop),
		.full  (full),
		.empty (empty),
		.wr_en (wr_en_w),
		.rd_en (rd_en_w)
	);

	// element storage
	ram_matrix ram_matrix_inst (
		.clk        (clk),
		.wr_en      (wr_en_w),
		.rd_en      (rd_en_w),
		.count_push (count_push_w),
		.count_pop  (count_pop_w),
		.data_in    (data_in),
		.data_out   (data_out)
	);

	// addresses, fill level and ready flag
	pointers_m pointers_m_inst (
		.clk        (clk),
		.reset      (reset),
		.push       (wr_en_w),
		.pop        (rd_en_w),
		.n          (n),
		.count_push (count_push_w),
		.count_pop  (count_pop_w),
		.full       (full),
		.empty      (empty),
		.ready      (ready)
	);

endmodule

//--- logic/vector_bank.sv
`timescale 1ns/1ps

module vector_bank import global_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  vec_we,
	input  idx_t  vec_index,
	input  data_t vec_data,
	input  idx_t  rd_index,
	output data_t rd_data
);

	// ======================================================================
	// operand vector
	// ======================================================================

	// one register per column
	data_t vec_regs [MAX_N];

	// host write, one element per edge
	// whole bank zeroed on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < MAX_N; i++) begin
				vec_regs[i] <= '0;
			end
		end else if (vec_we) begin
			vec_regs[vec_index] <= vec_data;
		end
	end

	// ======================================================================
	// engine read
	// ======================================================================

	// no latency
	// index follows the column arriving from the FIFO
	assign rd_data = vec_regs[rd_index];

endmodule

//--- logic/row_mac.sv
`timescale 1ns/1ps

module row_mac import global_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    start,
	input  nibble_t n,
	input  logic    ready,
	input  logic    empty,
	output logic    pop,
	input  data_t   fifo_data,
	output idx_t    rd_index,
	input  data_t   vec_elem,
	output logic    result_req,
	input  logic    result_ack,
	output acc_t    result_data,
	output idx_t    result_row,
	output logic    done
);

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_drain,
		st_request,
		st_release,
		st_finish
	} state_t;

	state_t state;

	// column of the next pop
	idx_t pop_col;
	// column of the element now on fifo_data
	idx_t acc_col;
	// row being summed
	idx_t row;
	// fifo_data holds a fresh element this cycle
	logic acc_en;
	// running row sum
	acc_t acc;

	logic last_col;
	logic last_row;
	logic acc_clr;
	logic [2*$bits(data_t)-1:0] product;

	// ======================================================================
	// control
	// ======================================================================

	assign last_col = ({1'b0, pop_col} == n - 4'd1);
	assign last_row = ({1'b0, row} == n - 4'd1);

	// one pop per cycle while fetching
	// stalls if the FIFO runs dry
	assign pop = (state == st_fetch) && !empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= st_idle;
			pop_col    <= '0;
			row        <= '0;
			acc_en     <= 1'b0;
			result_req <= 1'b0;
			done       <= 1'b0;
		end else begin
			// read latency of the FIFO
			acc_en <= pop;
			if (pop) begin
				pop_col <= pop_col + idx_t'(1);
			end
			case (state)
				// start accepted only with a full matrix waiting
				st_idle, st_finish: begin
					if (start && ready) begin
						state   <= st_fetch;
						pop_col <= '0;
						row     <= '0;
						done    <= 1'b0;
					end
				end
				st_fetch: begin
					if (pop && last_col) begin
						state <= st_drain;
					end
				end
				// wait for the last element to be summed
				st_drain: begin
					if (!acc_en) begin
						state      <= st_request;
						result_req <= 1'b1;
					end
				end
				// ack seen so req drops
				st_request: begin
					if (result_ack) begin
						state      <= st_release;
						result_req <= 1'b0;
					end
				end
				// ack released before the next row or the end
				st_release: begin
					if (!result_ack) begin
						if (last_row) begin
							state <= st_finish;
							done  <= 1'b1;
						end else begin
							state   <= st_fetch;
							row     <= row + idx_t'(1);
							pop_col <= '0;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// ======================================================================
	// multiply accumulate
	// ======================================================================

	// vector lookup follows the element in flight
	assign rd_index = acc_col;
	assign product  = fifo_data * vec_elem;

	// sum starts fresh before every row
	assign acc_clr = (state == st_idle) || (state == st_release) || (state == st_finish);

	always_ff @(posedge clk) begin
		if (pop) begin
			acc_col <= pop_col;
		end
		if (acc_clr) begin
			acc <= '0;
		end else if (acc_en) begin
			acc <= acc + acc_t'(product);
		end
	end

	assign result_data = acc;
	assign result_row  = row;

	// ======================================================================
	// checks
	// ======================================================================

	// payload held for the whole request phase
	a_result_stable: assert property (@(posedge clk) disable iff (reset)
		result_req && $past(result_req) |-> $stable(result_data) && $stable(result_row))
		else $error("result changed while result_req high");

	// new request only after the previous ack is gone
	a_req_after_ack: assert property (@(posedge clk) disable iff (reset)
		$rose(result_req) |-> !result_ack)
		else $error("result_req rose with result_ack still high");

	// a whole matrix is held at start so fetching never meets an empty FIFO
	a_fetch_not_empty: assert property (@(posedge clk) disable iff (reset)
		state == st_fetch |-> !empty)
		else $error("FIFO ran dry while fetching a row");

endmodule

//--- logic/matvec_top.sv
`timescale 1ns/1ps

module matvec_top import global_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    start,
	input  logic    push,
	input  data_t   data_in,
	input  nibble_t n,
	input  logic    vec_we,
	input  idx_t    vec_index,
	input  data_t   vec_data,
	output logic    full,
	output logic    result_req,
	input  logic    result_ack,
	output acc_t    result_data,
	output idx_t    result_row,
	output logic    done
);

	// FIFO to engine
	logic  empty;
	logic  ready;
	logic  pop;
	data_t fifo_data;

	// vector bank to engine
	idx_t  rd_index;
	data_t vec_elem;

	// ======================================================================
	// matrix storage
	// ======================================================================
	fifo_matrix fifo_matrix_inst (
		.clk      (clk),
		.reset    (reset),
		.push     (push),
		.pop      (pop),
		.data_in  (data_in),
		.n        (n),
		.full     (full),
		.empty    (empty),
		.data_out (fifo_data),
		.ready    (ready)
	);

	// ======================================================================
	// operand vector
	// ======================================================================
	vector_bank vector_bank_inst (
		.clk       (clk),
		.reset     (reset),
		.vec_we    (vec_we),
		.vec_index (vec_index),
		.vec_data  (vec_data),
		.rd_index  (rd_index),
		.rd_data   (vec_elem)
	);

	// ======================================================================
	// row engine
	// ======================================================================
	row_mac row_mac_inst (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.n           (n),
		.ready       (ready),
		.empty       (empty),
		.pop         (pop),
		.fifo_data   (fifo_data),
		.rd_index    (rd_index),
		.vec_elem    (vec_elem),
		.result_req  (result_req),
		.result_ack  (result_ack),
		.result_data (result_data),
		.result_row  (result_row),
		.done        (done)
	);

endmodule

//--- tests/matvec_checker.sv
`timescale 1ns/1ps

module matvec_checker import global_pkg::*, fifo_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    push,
	input  data_t   data_in,
	input  logic    full,
	input  nibble_t n,
	input  logic    vec_we,
	input  idx_t    vec_index,
	input  data_t   vec_data,
	input  logic    result_req,
	input  logic    result_ack,
	input  acc_t    result_data,
	input  idx_t    result_row,
	input  logic    done,
	output int      value_errors,
	output int      protocol_errors,
	output int      dropped_pushes,
	output int      rows_checked
);

	// mirror of the host writes
	data_t vec_model [MAX_N];
	data_t held_q [$];

	int value_err_cnt = 0;
	int proto_err_cnt = 0;
	int drop_cnt = 0;
	int row_cnt = 0;
	// row expected next within the current run
	int next_row = 0;

	logic prev_req = 1'b0;
	logic prev_ack = 1'b0;
	logic prev_done = 1'b0;
	logic prev_reset = 1'b1;

	assign value_errors    = value_err_cnt;
	assign protocol_errors = proto_err_cnt;
	assign dropped_pushes  = drop_cnt;
	assign rows_checked    = row_cnt;

	// row sum as defined for y = M * v
	function automatic int row_sum(input data_t row_elems [MAX_N], input data_t vec [MAX_N],
		input int cols);
		int sum;
		sum = 0;
		for (int j = 0; j < cols; j++) begin
			sum += int'(row_elems[j]) * int'(vec[j]);
		end
		return sum;
	endfunction

	// ======================================================================
	// model update and compare, sampled on the rising edge
	// ======================================================================
	always @(posedge clk) begin
		data_t row_elems [MAX_N];
		int expected;
		if (reset) begin
			held_q.delete();
			for (int i = 0; i < MAX_N; i++) begin
				vec_model[i] = '0;
			end
			next_row = 0;
		end else begin
			// idle outputs right after reset
			if (prev_reset && (result_req || done || full)) begin
				$display("outputs not idle after reset: req %0b done %0b full %0b",
					result_req, done, full);
				proto_err_cnt++;
			end
			// accepted pushes go to the model, dropped ones only while 64 held
			if (push && full) begin
				drop_cnt++;
				if (held_q.size() != FIFO_DEPTH) begin
					$display("full raised with only %0d elements held", held_q.size());
					proto_err_cnt++;
				end
			end else if (push) begin
				if (held_q.size() >= FIFO_DEPTH) begin
					$display("push accepted with %0d elements already held", held_q.size());
					proto_err_cnt++;
				end
				held_q.push_back(data_in);
			end
			if (vec_we) begin
				vec_model[vec_index] = vec_data;
			end
			// new result offered
			if (result_req && !prev_req) begin
				if (prev_ack || result_ack) begin
					$display("result_req rose while result_ack was still high");
					proto_err_cnt++;
				end
				if (held_q.size() < int'(n)) begin
					$display("result_req raised without a whole row loaded");
					proto_err_cnt++;
				end else begin
					for (int j = 0; j < MAX_N; j++) begin
						row_elems[j] = '0;
						if (j < int'(n)) begin
							row_elems[j] = held_q.pop_front();
						end
					end
					expected = row_sum(row_elems, vec_model, int'(n));
					if (int'(result_data) != expected) begin
						$display("error result_data row %0d: expected %0h got %0h",
							next_row, expected, result_data);
						value_err_cnt++;
					end
					if (int'(result_row) != next_row) begin
						$display("error result_row: expected %0h got %0h", next_row, result_row);
						value_err_cnt++;
					end
					row_cnt++;
					next_row++;
				end
			end
			// phase 3 only after phase 2
			if (prev_req && !result_req && !prev_ack) begin
				$display("result_req dropped before result_ack was raised");
				proto_err_cnt++;
			end
			// done closes a run of exactly n rows
			if (done && !prev_done) begin
				if (next_row != int'(n)) begin
					$display("done raised after %0d of %0d rows", next_row, n);
					proto_err_cnt++;
				end
				next_row = 0;
			end
		end
		prev_req   <= result_req;
		prev_ack   <= result_ack;
		prev_done  <= done;
		prev_reset <= reset;
	end

endmodule

//--- tests/matvec_tb.sv
`timescale 1ns/1ps

module matvec_tb import global_pkg::*; ();

	// ======================================================================
	// run length, the timeout follows from it
	// ======================================================================
	localparam int RUNS        = 8;
	localparam int MAX_PUSHES  = 64;
	localparam int ROW_CYCLES  = 25;
	localparam int MARGIN      = 500;
	localparam int CYCLE_LIMIT = RUNS * (MAX_PUSHES + MAX_N * ROW_CYCLES) + MARGIN;

	logic    clk;
	logic    reset;
	logic    start;
	logic    push;
	data_t   data_in;
	nibble_t n;
	logic    vec_we;
	idx_t    vec_index;
	data_t   vec_data;
	logic    full;
	logic    result_req;
	logic    result_ack;
	acc_t    result_data;
	idx_t    result_row;
	logic    done;

	int value_errors;
	int protocol_errors;
	int dropped_pushes;
	int rows_checked;
	int cycle_count = 0;
	int expected_rows = 0;
	// ack delay range in cycles
	int ack_min_delay = 0;
	int ack_max_delay = 5;
	// last matrix, kept for the vector rewrite run
	data_t saved_matrix [MAX_N*MAX_N];

	matvec_top matvec_top_inst (
		.clk(clk), .reset(reset), .start(start), .push(push), .data_in(data_in), .n(n),
		.vec_we(vec_we), .vec_index(vec_index), .vec_data(vec_data), .full(full),
		.result_req(result_req), .result_ack(result_ack), .result_data(result_data),
		.result_row(result_row), .done(done)
	);

	matvec_checker matvec_checker_inst (
		.clk(clk), .reset(reset), .push(push), .data_in(data_in), .full(full), .n(n),
		.vec_we(vec_we), .vec_index(vec_index), .vec_data(vec_data),
		.result_req(result_req), .result_ack(result_ack), .result_data(result_data),
		.result_row(result_row), .done(done), .value_errors(value_errors),
		.protocol_errors(protocol_errors), .dropped_pushes(dropped_pushes),
		.rows_checked(rows_checked)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// host side of the four-phase handshake
	initial begin
		int delay;
		result_ack = 1'b0;
		forever begin
			@(posedge clk);
			if (!reset && result_req && !result_ack) begin
				delay = $urandom_range(ack_max_delay, ack_min_delay);
				repeat (delay) @(posedge clk);
				result_ack <= 1'b1;
				@(posedge clk);
				while (result_req) @(posedge clk);
				delay = $urandom_range(ack_max_delay, ack_min_delay);
				repeat (delay) @(posedge clk);
				result_ack <= 1'b0;
			end
		end
	end

	task automatic print_counts(input int other);
		$display("closing: value errors %0d, protocol errors %0d, other failures %0d",
			value_errors, protocol_errors, other);
	endtask

	// run limit
	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout, the runs did not finish within %0d cycles", CYCLE_LIMIT);
		print_counts(1);
		$display("Test failed");
		$finish;
	end

	// ======================================================================
	// host tasks
	// ======================================================================
	task automatic write_vector(input bit all_max);
		for (int i = 0; i < MAX_N; i++) begin
			@(posedge clk);
			vec_we    <= 1'b1;
			vec_index <= idx_t'(i);
			vec_data  <= all_max ? 8'hff : data_t'($urandom_range(255, 0));
		end
		@(posedge clk);
		vec_we <= 1'b0;
	endtask

	task automatic push_elements(input int count, input bit all_max, input bit reuse);
		data_t value;
		for (int i = 0; i < count; i++) begin
			if (reuse) begin
				value = saved_matrix[i];
			end else begin
				value = all_max ? 8'hff : data_t'($urandom_range(255, 0));
			end
			if (i < MAX_N * MAX_N) begin
				saved_matrix[i] = value;
			end
			@(posedge clk);
			push    <= 1'b1;
			data_in <= value;
		end
		@(posedge clk);
		push <= 1'b0;
		// ready trails the last write by two edges
		repeat (3) @(posedge clk);
	endtask

	// one start pulse, then wait for done
	task automatic full_run(input nibble_t size, input int pushes, input bit all_max,
		input bit reuse);
		@(posedge clk);
		n <= size;
		write_vector(all_max);
		push_elements(pushes, all_max, reuse);
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		while (!done) @(posedge clk);
		expected_rows += int'(size);
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================
	initial begin
		nibble_t size;
		int other;
		void'($urandom(3621));
		reset     = 1'b1;
		start     = 1'b0;
		push      = 1'b0;
		data_in   = '0;
		n         = 4'd4;
		vec_we    = 1'b0;
		vec_index = '0;
		vec_data  = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		// start with nothing loaded must be ignored
		repeat (2) @(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		repeat (20) @(posedge clk);
		for (int r = 0; r < 3; r++) begin
			size = nibble_t'($urandom_range(MAX_N, 1));
			full_run(size, int'(size) * int'(size), 1'b0, 1'b0);
		end
		// largest row sum
		full_run(4'd8, 64, 1'b1, 1'b0);
		// one push too many
		full_run(4'd8, 65, 1'b0, 1'b0);
		// fast acks
		ack_min_delay = 0;
		ack_max_delay = 0;
		size = nibble_t'($urandom_range(MAX_N, 1));
		full_run(size, int'(size) * int'(size), 1'b0, 1'b0);
		// slow acks
		ack_min_delay = 5;
		ack_max_delay = 5;
		size = nibble_t'($urandom_range(MAX_N, 1));
		full_run(size, int'(size) * int'(size), 1'b0, 1'b0);
		// same matrix again under a new vector
		ack_min_delay = 0;
		ack_max_delay = 5;
		full_run(size, int'(size) * int'(size), 1'b0, 1'b1);
		repeat (10) @(posedge clk);
		other = 0;
		if (dropped_pushes != 1) begin
			$display("overflow run dropped %0d pushes instead of one", dropped_pushes);
			other++;
		end
		if (rows_checked != expected_rows) begin
			$display("%0d rows checked where %0d were expected", rows_checked, expected_rows);
			other++;
		end
		print_counts(other);
		if (value_errors == 0 && protocol_errors == 0 && other == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- all.f
logic/global_pkg.sv
logic/fifo_pkg.sv
logic/fsm_fifo.sv
logic/ram_matrix.sv
logic/pointers_m.sv
logic/fifo_matrix.sv
logic/vector_bank.sv
logic/row_mac.sv
logic/matvec_top.sv
tests/matvec_checker.sv
tests/matvec_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module matvec_tb &&
./obj_dir/Vmatvec_tb | tee /dev/stderr | grep "Test completed successfully" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation did not pass"; exit 1; }
